/* run_sim.sh */
#!/bin/sh
# build with verilator, run once into sim.log, pass only if the log holds the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_top -f sim.f \
    && ./obj_dir/Vtb_top | tee sim.log \
    && grep -q "^No errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim.f */
source/mcu_pkg.sv
source/code_ram.sv
source/move_core.sv
source/reg_bank.sv
source/av_master_port.sv
source/mcu_top.sv
sim/tb_checker.sv
sim/tb_top.sv

/* sim/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input logic        sysclk,
    input logic        rst,
    input logic [7:0]  led,
    input logic [15:0] av_address,
    input logic [15:0] av_writedata,
    input logic        av_write,
    input logic        av_waitrequest,
    input logic        halted
);

    // expected events, in program order
    logic [7:0]  exp_led [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];

    int mismatch_count;
    int event_count;
    int protocol_count;

    // samples from the previous edge
    logic        rst_q;
    logic        halted_q;
    logic        write_q;
    logic        wait_q;
    logic [7:0]  led_q;
    logic [15:0] addr_q;
    logic [15:0] data_q;

    initial begin
        mismatch_count = 0;
        event_count = 0;
        protocol_count = 0;
        rst_q = 1'b0;
    end

    task automatic add_led(input logic [7:0] v);
        exp_led.push_back(v);
    endtask

    task automatic add_xfer(input logic [15:0] a, input logic [15:0] d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    // leftovers are events the DUT never produced
    task automatic finish_program();
        if (exp_led.size() != 0) begin
            $display("%0t: %0d expected LED changes never happened", $time, exp_led.size());
            event_count++;
        end
        if (exp_addr.size() != 0) begin
            $display("%0t: %0d expected transfers never happened", $time, exp_addr.size());
            event_count++;
        end
        exp_led.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        if (got !== exp) begin
            $display("MISMATCH %0t %s expected %h got %h", $time, name, exp, got);
            mismatch_count++;
        end
    endtask

    always @(posedge sysclk) begin
        logic [7:0] e_led;
        if (rst_q) begin
            // reset values, also while the loader writes
            check_value("led", 16'h0000, {8'h00, led});
            check_value("av_write", 16'h0000, {15'd0, av_write});
            check_value("halted", 16'h0000, {15'd0, halted});
        end else if (!rst) begin
            if (led != led_q) begin
                if (exp_led.size() == 0) begin
                    $display("%0t: unexpected LED change to %h", $time, led);
                    event_count++;
                end else begin
                    e_led = exp_led.pop_front();
                    check_value("led", {8'h00, e_led}, {8'h00, led});
                end
            end
            // transfer accepted at this edge
            if (av_write && !av_waitrequest) begin
                if (exp_addr.size() == 0) begin
                    $display("%0t: unexpected transfer to %h", $time, av_address);
                    event_count++;
                end else begin
                    check_value("av_address", exp_addr.pop_front(), av_address);
                    check_value("av_writedata", exp_data.pop_front(), av_writedata);
                end
            end
            // held off last edge, must still be presented unchanged
            if (write_q && wait_q) begin
                if (!av_write) begin
                    $display("%0t: av_write dropped while waitrequest was high", $time);
                    protocol_count++;
                end
                check_value("av_address", addr_q, av_address);
                check_value("av_writedata", data_q, av_writedata);
            end
            // only a pending write may still finish once halted
            if (halted_q) begin
                if (led != led_q || av_address != addr_q || av_writedata != data_q ||
                    (av_write && !write_q)) begin
                    $display("%0t: outputs changed after the core halted", $time);
                    protocol_count++;
                end
                if (!halted) begin
                    $display("%0t: halted fell without a reset", $time);
                    protocol_count++;
                end
            end
        end
        rst_q <= rst;
        halted_q <= halted;
        write_q <= av_write;
        wait_q <= av_waitrequest;
        led_q <= led;
        addr_q <= av_address;
        data_q <= av_writedata;
    end

endmodule

`default_nettype wire

/* sim/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int num_progs = 20;
    localparam int max_words = 40;
    // per word: 2 run cycles, 1 load cycle, 16 spare for waitrequest runs
    localparam int watchdog_cycles = num_progs * (max_words + 1) * (2 + 1 + 16) + 100;

    logic        sysclk;
    logic        rst;
    logic        prog_write;
    logic [7:0]  prog_address;
    logic [15:0] prog_writedata;
    logic [1:0]  keys;
    logic [7:0]  led;
    logic [15:0] av_address;
    logic [15:0] av_writedata;
    logic        av_write;
    logic        av_waitrequest;
    logic        halted;

    logic [31:0] lfsr_state;
    // program words, halt at prog_len
    logic [15:0] prog [0:max_words];
    int          prog_len;
    // isa model state
    logic [15:0] m_gp [0:7];
    logic [7:0]  m_led;
    logic [15:0] m_wdata;
    logic [15:0] m_addr;

    mcu_top uut (
        .sysclk        (sysclk),
        .rst           (rst),
        .prog_write    (prog_write),
        .prog_address  (prog_address),
        .prog_writedata(prog_writedata),
        .keys          (keys),
        .led           (led),
        .av_address    (av_address),
        .av_writedata  (av_writedata),
        .av_write      (av_write),
        .av_waitrequest(av_waitrequest),
        .halted        (halted)
    );

    tb_checker chk (
        .sysclk        (sysclk),
        .rst           (rst),
        .led           (led),
        .av_address    (av_address),
        .av_writedata  (av_writedata),
        .av_write      (av_write),
        .av_waitrequest(av_waitrequest),
        .halted        (halted)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // n fresh bits, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // operand reg; ctrl and wait reads depend on timing, so bump them
    function automatic logic [3:0] pick_src();
        logic [3:0] r;
        r = 4'(rand_bits(4));
        if (r == 4'd11 || r == 4'd13) begin
            r = r + 4'd1;
        end
        return r;
    endfunction

    // leds and ctrl favoured so every program shows something
    function automatic logic [3:0] pick_dest();
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        if (sel == 2'd0) begin
            return mcu_pkg::r_leds;
        end else if (sel == 2'd1) begin
            return mcu_pkg::r_av_ctrl;
        end
        return 4'(rand_bits(4));
    endfunction

    function automatic logic [15:0] model_read(input logic [3:0] a);
        if (a < 4'd8) begin
            return m_gp[a[2:0]];
        end
        case (a)
            mcu_pkg::r_leds:         return {8'h00, m_led};
            mcu_pkg::r_av_writedata: return m_wdata;
            mcu_pkg::r_av_address:   return m_addr;
            mcu_pkg::r_keys:         return {14'd0, keys};
            default:                 return 16'h0000;
        endcase
    endfunction

    // register write, emits the visible events
    task automatic model_write(input logic [3:0] d, input logic [15:0] v);
        if (d < 4'd8) begin
            m_gp[d[2:0]] = v;
        end else if (d == mcu_pkg::r_leds) begin
            // equal values collapse
            if (v[7:0] != m_led) begin
                chk.add_led(v[7:0]);
            end
            m_led = v[7:0];
        end else if (d == mcu_pkg::r_av_writedata) begin
            m_wdata = v;
        end else if (d == mcu_pkg::r_av_address) begin
            m_addr = v;
        end else if (d == mcu_pkg::r_av_ctrl && v[0]) begin
            chk.add_xfer(m_addr, m_wdata);
        end
    endtask

    task automatic model_exec(input logic [15:0] w);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        if (w[15]) begin
            model_write(w[14:11], {5'd0, w[10:0]});
        end else begin
            a = model_read(w[7:4]);
            b = model_read(w[3:0]);
            case (w[14:12])
                mcu_pkg::op_mov: r = a;
                mcu_pkg::op_add: r = a + b;
                mcu_pkg::op_sub: r = a - b;
                mcu_pkg::op_and: r = a & b;
                mcu_pkg::op_or:  r = a | b;
                mcu_pkg::op_xor: r = a ^ b;
                default:         r = 16'h0000;
            endcase
            model_write(w[11:8], r);
        end
    endtask

    // random words with legal fields, then halt or the reserved op
    task automatic make_program();
        logic [2:0] op;
        logic [3:0] d;
        logic [3:0] sa;
        logic [3:0] sb;
        prog_len = 10 + int'(rand_bits(5)) % 31;
        for (int i = 0; i < prog_len; i++) begin
            if (rand_bits(1) == 32'd1) begin
                d = pick_dest();
                prog[i] = {1'b1, d, 11'(rand_bits(11))};
            end else begin
                op = 3'(int'(rand_bits(3)) % 6);
                d = pick_dest();
                sa = pick_src();
                sb = pick_src();
                prog[i] = {1'b0, op, d, sa, sb};
            end
        end
        prog[prog_len] = {1'b0, 2'b11, 13'(rand_bits(13))};
    endtask

    task automatic run_program();
        make_program();
        @(posedge sysclk);
        #2;
        rst = 1'b1;
        av_waitrequest = 1'b0;
        keys = 2'(rand_bits(2));
        // fresh model state, expected events for this run
        for (int i = 0; i < 8; i++) begin
            m_gp[i] = 16'h0000;
        end
        m_led = 8'h00;
        m_wdata = 16'h0000;
        m_addr = 16'h0000;
        for (int i = 0; i < prog_len; i++) begin
            model_exec(prog[i]);
        end
        // load one word per cycle under reset
        for (int i = 0; i <= prog_len; i++) begin
            prog_write = 1'b1;
            prog_address = 8'(i);
            prog_writedata = prog[i];
            @(posedge sysclk);
            #2;
        end
        prog_write = 1'b0;
        rst = 1'b0;
        // run until halted and the last transfer has gone
        while (!(halted && !av_write)) begin
            av_waitrequest = 1'(rand_bits(1));
            @(posedge sysclk);
            #2;
        end
        // quiet window after the halt
        repeat (4) begin
            av_waitrequest = 1'(rand_bits(1));
            @(posedge sysclk);
            #2;
        end
        chk.finish_program();
    endtask

    initial begin
        lfsr_state = 32'he7e1_9c98;
        rst = 1'b1;
        prog_write = 1'b0;
        prog_address = 8'h00;
        prog_writedata = 16'h0000;
        keys = 2'b00;
        av_waitrequest = 1'b0;
        repeat (4) @(posedge sysclk);
        for (int n = 0; n < num_progs; n++) begin
            run_program();
        end
        $display("value mismatches %0d, missing or extra events %0d, protocol errors %0d",
                 chk.mismatch_count, chk.event_count, chk.protocol_count);
        if (chk.mismatch_count + chk.event_count + chk.protocol_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // hard stop on a hung program
    initial begin
        repeat (watchdog_cycles) @(posedge sysclk);
        $display("timeout after %0d cycles, a program never reached halt", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* source/av_master_port.sv */
`timescale 1ns/1ps
`default_nettype none

module av_master_port (
    input  logic                           sysclk,
    input  logic                           rst,
    // write strobe from the core
    input  logic                           wr_en,
    input  logic [mcu_pkg::reg_aw-1:0]     wr_addr,
    input  logic [mcu_pkg::data_width-1:0] wr_data,
    // master bus
    input  logic                           av_waitrequest,
    output logic [mcu_pkg::data_width-1:0] av_address,
    output logic [mcu_pkg::data_width-1:0] av_writedata,
    output logic                           av_write,
    // pending write, back to the core
    output logic                           av_busy
);

    logic wr_data_sel;
    logic wr_addr_sel;
    logic wr_ctrl_sel;
    logic accepted;

    // own address decode
    assign wr_data_sel = wr_en && (wr_addr == mcu_pkg::r_av_writedata);
    assign wr_addr_sel = wr_en && (wr_addr == mcu_pkg::r_av_address);
    assign wr_ctrl_sel = wr_en && (wr_addr == mcu_pkg::r_av_ctrl);

    // slave takes the transfer on this edge
    assign accepted = av_write && !av_waitrequest;

    // address and data, frozen by the core stall while pending
    always_ff @(posedge sysclk) begin
        if (rst) begin
            av_address <= '0;
            av_writedata <= '0;
        end else begin
            if (wr_addr_sel) begin
                av_address <= wr_data;
            end
            if (wr_data_sel) begin
                av_writedata <= wr_data;
            end
        end
    end

    // write bit: set by ctrl bit 0, cleared on acceptance
    always_ff @(posedge sysclk) begin
        if (rst) begin
            av_write <= 1'b0;
        end else if (wr_ctrl_sel) begin
            // core only gets here when nothing is pending
            av_write <= wr_data[0];
        end else if (accepted) begin
            av_write <= 1'b0;
        end
    end

    assign av_busy = av_write;

endmodule

`default_nettype wire

/* source/code_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module code_ram (
    input  logic                        sysclk,
    // loader side
    input  logic                        prog_write,
    input  logic [mcu_pkg::code_aw-1:0] prog_address,
    input  logic [mcu_pkg::data_width-1:0] prog_writedata,
    // core side
    input  logic [mcu_pkg::code_aw-1:0] fetch_addr,
    output logic [mcu_pkg::data_width-1:0] fetch_data
);

    // program store, keeps contents across rst
    logic [mcu_pkg::data_width-1:0] mem [0:mcu_pkg::code_depth-1];

    // loader write, one word per strobe
    always_ff @(posedge sysclk) begin
        if (prog_write) begin
            mem[prog_address] <= prog_writedata;
        end
    end

    // registered fetch, data valid one cycle after the address
    // old contents if loader hits the same word this cycle
    always_ff @(posedge sysclk) begin
        fetch_data <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

/* source/mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

    // datapath and memory sizes
    localparam int data_width = 16;
    localparam int code_depth = 256;
    localparam int code_aw = 8;
    localparam int reg_aw = 4;
    localparam int led_width = 8;
    localparam int key_width = 2;

    // general purpose block bounds
    localparam logic [reg_aw-1:0] r_gp0 = 4'd0;
    localparam logic [reg_aw-1:0] r_gp7 = 4'd7;

    // mapped writable registers
    localparam logic [reg_aw-1:0] r_leds = 4'd8;
    localparam logic [reg_aw-1:0] r_av_writedata = 4'd9;
    localparam logic [reg_aw-1:0] r_av_address = 4'd10;
    // bit 0 is the write request
    localparam logic [reg_aw-1:0] r_av_ctrl = 4'd11;

    // read-only sources
    localparam logic [reg_aw-1:0] r_keys = 4'd12;
    localparam logic [reg_aw-1:0] r_av_wait = 4'd13;
    // 14 and 15 fall through to zero

    // alu opcodes
    localparam logic [2:0] op_mov = 3'd0;
    localparam logic [2:0] op_add = 3'd1;
    localparam logic [2:0] op_sub = 3'd2;
    localparam logic [2:0] op_and = 3'd3;
    localparam logic [2:0] op_or = 3'd4;
    localparam logic [2:0] op_xor = 3'd5;
    localparam logic [2:0] op_halt = 3'd6;
    // reserved, treated like halt
    localparam logic [2:0] op_rsvd = 3'd7;

    // core sequencer states
    localparam logic [1:0] st_fetch = 2'd0;
    localparam logic [1:0] st_exec = 2'd1;
    localparam logic [1:0] st_halt = 2'd2;

    // one code word, two decodings picked by bit 15
    typedef union packed {
        // flag set: load zero-extended immediate
        struct packed {
            logic        flag;
            logic [3:0]  dest;
            logic [10:0] imm;
        } imm;
        // flag clear: register op, mov copies src_a
        struct packed {
            logic       flag;
            logic [2:0] op;
            logic [3:0] dest;
            logic [3:0] src_a;
            logic [3:0] src_b;
        } alu;
    } instr_t;

endpackage

`default_nettype wire

/* source/mcu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_top (
    input  logic                           sysclk,
    input  logic                           rst,
    // program load port
    input  logic                           prog_write,
    input  logic [mcu_pkg::code_aw-1:0]    prog_address,
    input  logic [mcu_pkg::data_width-1:0] prog_writedata,
    // board i/o
    input  logic [mcu_pkg::key_width-1:0]  keys,
    output logic [mcu_pkg::led_width-1:0]  led,
    // write master
    output logic [mcu_pkg::data_width-1:0] av_address,
    output logic [mcu_pkg::data_width-1:0] av_writedata,
    output logic                           av_write,
    input  logic                           av_waitrequest,
    output logic                           halted
);

    logic [mcu_pkg::code_aw-1:0]    fetch_addr;
    logic [mcu_pkg::data_width-1:0] fetch_data;
    logic [mcu_pkg::reg_aw-1:0]     rd_addr_a;
    logic [mcu_pkg::reg_aw-1:0]     rd_addr_b;
    logic [mcu_pkg::data_width-1:0] rd_data_a;
    logic [mcu_pkg::data_width-1:0] rd_data_b;
    logic                           wr_en;
    logic [mcu_pkg::reg_aw-1:0]     wr_addr;
    logic [mcu_pkg::data_width-1:0] wr_data;
    logic                           av_busy;

    // program store
    code_ram u_code_ram (
        .sysclk        (sysclk),
        .prog_write    (prog_write),
        .prog_address  (prog_address),
        .prog_writedata(prog_writedata),
        .fetch_addr    (fetch_addr),
        .fetch_data    (fetch_data)
    );

    // sequencer and alu
    move_core u_core (
        .sysclk    (sysclk),
        .rst       (rst),
        .fetch_addr(fetch_addr),
        .fetch_data(fetch_data),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .av_busy   (av_busy),
        .halted    (halted)
    );

    // gp, led and the read map
    reg_bank u_reg_bank (
        .sysclk        (sysclk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .keys          (keys),
        .av_waitrequest(av_waitrequest),
        .av_address    (av_address),
        .av_writedata  (av_writedata),
        .av_write      (av_write),
        .led           (led)
    );

    // write master registers
    av_master_port u_av_master (
        .sysclk        (sysclk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .av_waitrequest(av_waitrequest),
        .av_address    (av_address),
        .av_writedata  (av_writedata),
        .av_write      (av_write),
        .av_busy       (av_busy)
    );

endmodule

`default_nettype wire

/* source/move_core.sv */
`timescale 1ns/1ps
`default_nettype none

module move_core (
    input  logic                           sysclk,
    input  logic                           rst,
    // code memory
    output logic [mcu_pkg::code_aw-1:0]    fetch_addr,
    input  logic [mcu_pkg::data_width-1:0] fetch_data,
    // register reads
    output logic [mcu_pkg::reg_aw-1:0]     rd_addr_a,
    output logic [mcu_pkg::reg_aw-1:0]     rd_addr_b,
    input  logic [mcu_pkg::data_width-1:0] rd_data_a,
    input  logic [mcu_pkg::data_width-1:0] rd_data_b,
    // register write strobe
    output logic                           wr_en,
    output logic [mcu_pkg::reg_aw-1:0]     wr_addr,
    output logic [mcu_pkg::data_width-1:0] wr_data,
    // master back-pressure
    input  logic                           av_busy,
    output logic                           halted
);

    logic [1:0]                     state;
    logic [mcu_pkg::code_aw-1:0]    pc;
    mcu_pkg::instr_t                instr;
    logic                           is_imm;
    logic                           is_halt;
    logic [mcu_pkg::reg_aw-1:0]     dest;
    logic                           av_dest;
    logic                           stall;
    logic                           exec_go;
    logic [mcu_pkg::data_width-1:0] result;

    // fetch_data is only meaningful in exec
    assign instr = fetch_data;

    // pc goes straight to the ram, no branches
    assign fetch_addr = pc;

    // decode
    assign is_imm = instr.imm.flag;
    assign is_halt = !is_imm &&
        (instr.alu.op == mcu_pkg::op_halt || instr.alu.op == mcu_pkg::op_rsvd);
    assign dest = is_imm ? instr.imm.dest : instr.alu.dest;

    // operand addresses from the alu view, ignored for immediates
    assign rd_addr_a = instr.alu.src_a;
    assign rd_addr_b = instr.alu.src_b;

    // master regs may not change while a write is pending
    assign av_dest = dest inside {mcu_pkg::r_av_writedata,
                                  mcu_pkg::r_av_address,
                                  mcu_pkg::r_av_ctrl};
    assign stall = av_dest && av_busy && !is_halt;

    // execute completes this cycle
    assign exec_go = (state == mcu_pkg::st_exec) && !stall;

    // alu and immediate select
    always_comb begin
        if (is_imm) begin
            result = {{(mcu_pkg::data_width - 11){1'b0}}, instr.imm.imm};
        end else begin
            case (instr.alu.op)
                mcu_pkg::op_mov: result = rd_data_a;
                mcu_pkg::op_add: result = rd_data_a + rd_data_b;
                mcu_pkg::op_sub: result = rd_data_a - rd_data_b;
                mcu_pkg::op_and: result = rd_data_a & rd_data_b;
                mcu_pkg::op_or:  result = rd_data_a | rd_data_b;
                mcu_pkg::op_xor: result = rd_data_a ^ rd_data_b;
                // halt and reserved never write
                default:         result = '0;
            endcase
        end
    end

    // single-cycle write strobe at the end of exec
    assign wr_en = exec_go && !is_halt;
    assign wr_addr = dest;
    assign wr_data = result;

    // fetch -> exec -> fetch, or exec -> halt
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= mcu_pkg::st_fetch;
            pc <= '0;
        end else begin
            case (state)
                mcu_pkg::st_fetch: begin
                    // ram is reading mem[pc] on this edge
                    state <= mcu_pkg::st_exec;
                end
                mcu_pkg::st_exec: begin
                    if (exec_go) begin
                        if (is_halt) begin
                            state <= mcu_pkg::st_halt;
                        end else begin
                            pc <= pc + 1'b1;
                            state <= mcu_pkg::st_fetch;
                        end
                    end
                    // stalled: hold, same word re-read each cycle
                end
                mcu_pkg::st_halt: begin
                    // parked until rst
                    state <= mcu_pkg::st_halt;
                end
                default: begin
                    state <= mcu_pkg::st_fetch;
                end
            endcase
        end
    end

    // high from the cycle after the halt word
    assign halted = (state == mcu_pkg::st_halt);

endmodule

`default_nettype wire

/* source/reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  logic                           sysclk,
    input  logic                           rst,
    // write strobe from the core
    input  logic                           wr_en,
    input  logic [mcu_pkg::reg_aw-1:0]     wr_addr,
    input  logic [mcu_pkg::data_width-1:0] wr_data,
    // two read ports
    input  logic [mcu_pkg::reg_aw-1:0]     rd_addr_a,
    input  logic [mcu_pkg::reg_aw-1:0]     rd_addr_b,
    output logic [mcu_pkg::data_width-1:0] rd_data_a,
    output logic [mcu_pkg::data_width-1:0] rd_data_b,
    // mapped inputs
    input  logic [mcu_pkg::key_width-1:0]  keys,
    input  logic                           av_waitrequest,
    input  logic [mcu_pkg::data_width-1:0] av_address,
    input  logic [mcu_pkg::data_width-1:0] av_writedata,
    input  logic                           av_write,
    output logic [mcu_pkg::led_width-1:0]  led
);

    logic [mcu_pkg::data_width-1:0] gp [0:7];
    // only the led bits are stored
    logic [mcu_pkg::led_width-1:0]  leds;

    // general purpose and led writes
    always_ff @(posedge sysclk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                gp[i] <= '0;
            end
            leds <= '0;
        end else if (wr_en) begin
            if (wr_addr inside {[mcu_pkg::r_gp0:mcu_pkg::r_gp7]}) begin
                gp[wr_addr[2:0]] <= wr_data;
            end else if (wr_addr == mcu_pkg::r_leds) begin
                leds <= wr_data[mcu_pkg::led_width-1:0];
            end
            // 9 to 11 belong to av_master_port and 12 to 15 are dropped
        end
    end

    assign led = leds;

    // one source per address over the full register map
    function automatic logic [mcu_pkg::data_width-1:0] reg_read(
        input logic [mcu_pkg::reg_aw-1:0] addr
    );
        logic [mcu_pkg::data_width-1:0] val;
        val = '0;
        if (addr inside {[mcu_pkg::r_gp0:mcu_pkg::r_gp7]}) begin
            val = gp[addr[2:0]];
        end else begin
            case (addr)
                mcu_pkg::r_leds:         val[mcu_pkg::led_width-1:0] = leds;
                mcu_pkg::r_av_writedata: val = av_writedata;
                mcu_pkg::r_av_address:   val = av_address;
                mcu_pkg::r_av_ctrl:      val = {{(mcu_pkg::data_width - 1){1'b0}}, av_write};
                mcu_pkg::r_keys:         val[mcu_pkg::key_width-1:0] = keys;
                mcu_pkg::r_av_wait:      val = {{(mcu_pkg::data_width - 1){1'b0}}, av_waitrequest};
                // 14, 15 read zero
                default:                 val = '0;
            endcase
        end
        return val;
    endfunction

    always_comb begin
        rd_data_a = reg_read(rd_addr_a);
        rd_data_b = reg_read(rd_addr_b);
    end

endmodule

`default_nettype wire
